//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // bus and instruction widths
    localparam int BYTE_W  = 8;
    localparam int INSTR_W = 16;
    localparam int PC_W    = 8;
    localparam int DEV_W   = 5;

    // program rom depth and data ram size
    localparam int ROM_WORDS = 1 << PC_W;
    localparam int RAM_BYTES = 1 << BYTE_W;

    typedef logic [BYTE_W-1:0]  byte_t;
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [PC_W-1:0]    pc_t;
    typedef logic [DEV_W-1:0]   dev_t;

    // operation field in bits 7:5 of the high byte
    typedef enum logic [2:0] {
        op_dev_rom       = 3'd0,
        op_dev_ram       = 3'd1,
        op_dev_ramzp     = 3'd2,
        op_dev_uart      = 3'd3,
        op_nonreg_opregy = 3'd4,
        op_regx_alu      = 3'd5,
        op_ramzp_reg     = 3'd6,
        op_ramzp_uart    = 3'd7
    } opcode_e;

    // alu code in low three bits of the low byte
    // code 7 is unused and yields zero
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_pass_x = 3'd5,
        alu_pass_y = 3'd6
    } alu_op_e;

    // write targets, top bit marks the register block
    localparam dev_t dev_none    = 5'd0;
    localparam dev_t dev_ram     = 5'd1;
    localparam dev_t dev_uart_tx = 5'd2;
    localparam dev_t dev_reg_a   = 5'd16;
    localparam dev_t dev_reg_x   = 5'd17;
    localparam dev_t dev_reg_y   = 5'd18;
    localparam dev_t dev_reg_m   = 5'd19;

    // queue slots and credits toward execution
    localparam int QUEUE_DEPTH  = 4;
    localparam int EXEC_CREDITS = 1;

    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int ECNT_W = $clog2(EXEC_CREDITS + 1);

    typedef logic [QPTR_W-1:0] qptr_t;
    typedef logic [QCNT_W-1:0] qcnt_t;
    typedef logic [ECNT_W-1:0] ecnt_t;

endpackage

`default_nettype wire

//--- hw/control_selector.sv
`timescale 1ns/1ps
`default_nettype none

module control_selector (
    input  wire cpu_pkg::byte_t  hi_rom,
    output logic                 rom_out_n,
    output logic                 ram_out_n,
    output logic                 alu_out_n,
    output logic                 uart_out_n,
    output logic                 force_alu_op_to_passx,
    output logic                 force_x_val_to_zero,
    output logic                 ram_zp_n,
    output cpu_pkg::dev_t        device_in
);
    import cpu_pkg::*;

    opcode_e    op;
    // one-hot operation decode
    logic [7:0] op_hot;
    logic       ram_write_override;
    logic       top_bit;

    assign op     = opcode_e'(hi_rom[7:5]);
    assign op_hot = 8'b1 << op;

    // bus source selects, active low
    assign rom_out_n  = !op_hot[op_dev_rom];
    assign ram_out_n  = !(op_hot[op_dev_ram] || op_hot[op_dev_ramzp]);
    assign alu_out_n  = !(op_hot[op_nonreg_opregy] || op_hot[op_regx_alu]
                          || op_hot[op_ramzp_reg]);
    assign uart_out_n = !(op_hot[op_dev_uart] || op_hot[op_ramzp_uart]);

    // ram addressed by the low byte instead of M
    assign ram_zp_n = !(op_hot[op_dev_ramzp] || op_hot[op_ramzp_reg]
                        || op_hot[op_ramzp_uart]);

    // alu operand overrides
    assign force_x_val_to_zero   = op_hot[op_nonreg_opregy];
    assign force_alu_op_to_passx = op_hot[op_ramzp_reg];

    // zero-page stores have no device target
    assign ram_write_override = op_hot[op_ramzp_reg] || op_hot[op_ramzp_uart];

    // top device bit picks the register block
    always_comb begin
        if (op_hot[op_regx_alu]) begin
            top_bit = 1'b1;
        end else if (op_hot[op_nonreg_opregy]) begin
            top_bit = 1'b0;
        end else begin
            top_bit = hi_rom[0];
        end
    end

    // device code is bit 0 rotated above bits 4:1
    assign device_in = ram_write_override ? dev_none : {top_bit, hi_rom[4:1]};

endmodule

`default_nettype wire

//--- hw/program_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module program_fetch (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   prog_we,
    input  wire cpu_pkg::pc_t     prog_addr,
    input  wire cpu_pkg::instr_t  prog_data,
    input  wire                   run,
    input  wire cpu_pkg::pc_t     prog_len,
    input  wire                   fetch_credit,
    output logic                  instr_valid,
    output cpu_pkg::instr_t       instr_data
);
    import cpu_pkg::*;

    // program store loaded from outside
    instr_t rom [ROM_WORDS];

    pc_t   pc;
    // free slots left in the queue
    qcnt_t credit_cnt;
    logic  issue;

    // load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            rom[prog_addr] <= prog_data;
        end
    end

    // one word per cycle while running, credited and inside the program
    assign issue = run && (credit_cnt != '0) && (pc < prog_len);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= '0;
            credit_cnt  <= qcnt_t'(QUEUE_DEPTH);
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= issue;
            if (issue) begin
                pc <= pc + 1'b1;
            end
            // spend on issue, refill on returned credit
            credit_cnt <= credit_cnt - qcnt_t'(issue) + qcnt_t'(fetch_credit);
        end
    end

    // rom read registered alongside the valid flag
    always_ff @(posedge clk) begin
        if (issue) begin
            instr_data <= rom[pc];
        end
    end

    // the queue never hands back more than it has slots
    assert property (@(posedge clk) disable iff (!arst_n)
        credit_cnt <= qcnt_t'(QUEUE_DEPTH));

endmodule

`default_nettype wire

//--- hw/instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module instr_queue (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   instr_valid,
    input  wire cpu_pkg::instr_t  instr_data,
    output logic                  fetch_credit,
    input  wire                   exec_credit,
    output logic                  exec_valid,
    output cpu_pkg::instr_t       exec_instr
);
    import cpu_pkg::*;

    instr_t mem [QUEUE_DEPTH];

    qptr_t wr_ptr;
    qptr_t rd_ptr;
    // entries held
    qcnt_t count;
    // free instruction slots in the execution unit
    ecnt_t credit_cnt;

    // circular pointer step
    function automatic qptr_t next_ptr(input qptr_t ptr);
        qptr_t nxt;
        if (ptr == qptr_t'(QUEUE_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // head goes out whenever there is an entry and a credit
    assign exec_valid = (count != '0) && (credit_cnt != '0);
    assign exec_instr = mem[rd_ptr];

    // entry storage
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            mem[wr_ptr] <= instr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            credit_cnt   <= ecnt_t'(EXEC_CREDITS);
            fetch_credit <= 1'b0;
        end else begin
            if (instr_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (exec_valid) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + qcnt_t'(instr_valid) - qcnt_t'(exec_valid);
            // spend toward execution, refill on retire
            credit_cnt <= credit_cnt - ecnt_t'(exec_valid) + ecnt_t'(exec_credit);
            // freed slot goes back to fetch one cycle later
            fetch_credit <= exec_valid;
        end
    end

    // fetch credits keep writes out of a full queue
    assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid |-> count != qcnt_t'(QUEUE_DEPTH));

    // execution never returns more credits than it was given
    assert property (@(posedge clk) disable iff (!arst_n)
        exec_credit |-> credit_cnt != ecnt_t'(EXEC_CREDITS));

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   exec_valid,
    input  wire cpu_pkg::instr_t  exec_instr,
    output logic                  exec_credit,
    input  wire                   rx_valid,
    input  wire cpu_pkg::byte_t   rx_data,
    output logic                  rx_ready,
    output logic                  tx_valid,
    output cpu_pkg::byte_t        tx_data,
    input  wire                   tx_ready
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_execute,
        st_wait_io
    } state_e;

    state_e state;
    instr_t ir;
    byte_t  hi;
    byte_t  lo;
    byte_t  reg_a;
    byte_t  reg_x;
    byte_t  reg_y;
    byte_t  reg_m;
    byte_t  ram [RAM_BYTES];

    logic    rom_out_n;
    logic    ram_out_n;
    logic    alu_out_n;
    logic    uart_out_n;
    logic    force_alu_op_to_passx;
    logic    force_x_val_to_zero;
    logic    ram_zp_n;
    dev_t    device_in;
    logic    use_acc;
    alu_op_e alu_op;
    byte_t   alu_x;
    byte_t   alu_res;
    byte_t   ram_addr;
    byte_t   bus;
    logic    src_ok;
    logic    writes_tx;
    logic    commit;
    logic    ram_zp_write;

    assign hi = ir[15:8];
    assign lo = ir[7:0];

    control_selector i_control_selector (
        .hi_rom                (hi),
        .rom_out_n             (rom_out_n),
        .ram_out_n             (ram_out_n),
        .alu_out_n             (alu_out_n),
        .uart_out_n            (uart_out_n),
        .force_alu_op_to_passx (force_alu_op_to_passx),
        .force_x_val_to_zero   (force_x_val_to_zero),
        .ram_zp_n              (ram_zp_n),
        .device_in             (device_in)
    );

    // low byte bit 3 swaps A in for X on register alu ops
    assign use_acc = (opcode_e'(hi[7:5]) == op_regx_alu) && lo[3];
    assign alu_x   = force_x_val_to_zero ? '0 : (use_acc ? reg_a : reg_x);
    assign alu_op  = force_alu_op_to_passx ? alu_pass_x : alu_op_e'(lo[2:0]);

    // 8 bit alu without carry out
    always_comb begin
        case (alu_op)
            alu_add:    alu_res = alu_x + reg_y;
            alu_sub:    alu_res = alu_x - reg_y;
            alu_and:    alu_res = alu_x & reg_y;
            alu_or:     alu_res = alu_x | reg_y;
            alu_xor:    alu_res = alu_x ^ reg_y;
            alu_pass_x: alu_res = alu_x;
            alu_pass_y: alu_res = reg_y;
            default:    alu_res = '0;
        endcase
    end

    // zero page or M addressed
    assign ram_addr = ram_zp_n ? reg_m : lo;

    // bus driver
    always_comb begin
        if (!rom_out_n) begin
            bus = lo;
        end else if (!ram_out_n) begin
            bus = ram[ram_addr];
        end else if (!alu_out_n) begin
            bus = alu_res;
        end else begin
            bus = rx_data;
        end
    end

    // receiver reads wait for a byte
    assign src_ok       = uart_out_n || rx_valid;
    assign writes_tx    = (device_in == dev_uart_tx);
    assign commit       = (state == st_execute) && src_ok;
    assign ram_zp_write = !ram_zp_n && ram_out_n;
    assign rx_ready     = (state == st_execute) && !uart_out_n;

    // retire pulse goes back to the queue as a credit
    assign exec_credit = (commit && !writes_tx) || ((state == st_wait_io) && tx_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            tx_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (exec_valid) begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    if (src_ok && writes_tx) begin
                        tx_valid <= 1'b1;
                        state    <= st_wait_io;
                    end else if (src_ok) begin
                        state <= st_idle;
                    end
                end
                st_wait_io: begin
                    // held until the transmitter takes it
                    if (tx_ready) begin
                        tx_valid <= 1'b0;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // instruction and transmit byte
    always_ff @(posedge clk) begin
        if (state == st_idle && exec_valid) begin
            ir <= exec_instr;
        end
        if (commit && writes_tx) begin
            tx_data <= bus;
        end
    end

    // register block
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_a <= '0;
            reg_x <= '0;
            reg_y <= '0;
            reg_m <= '0;
        end else if (commit) begin
            case (device_in)
                dev_reg_a: reg_a <= bus;
                dev_reg_x: reg_x <= bus;
                dev_reg_y: reg_y <= bus;
                dev_reg_m: reg_m <= bus;
                default: ;
            endcase
        end
    end

    // data ram written by zero-page store or M target
    always_ff @(posedge clk) begin
        if (commit && ram_zp_write) begin
            ram[lo] <= bus;
        end else if (commit && device_in == dev_ram) begin
            ram[reg_m] <= bus;
        end
    end

    // queue only offers while the single slot is free
    assert property (@(posedge clk) disable iff (!arst_n)
        exec_valid |-> state == st_idle);

endmodule

`default_nettype wire

//--- hw/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   prog_we,
    input  wire cpu_pkg::pc_t     prog_addr,
    input  wire cpu_pkg::instr_t  prog_data,
    input  wire                   run,
    input  wire cpu_pkg::pc_t     prog_len,
    input  wire                   rx_valid,
    input  wire cpu_pkg::byte_t   rx_data,
    output logic                  rx_ready,
    output logic                  tx_valid,
    output cpu_pkg::byte_t        tx_data,
    input  wire                   tx_ready
);
    import cpu_pkg::*;

    // fetch to queue link
    logic   instr_valid;
    instr_t instr_data;
    logic   fetch_credit;

    // queue to execution link
    logic   exec_valid;
    instr_t exec_instr;
    logic   exec_credit;

    program_fetch i_program_fetch (
        .clk          (clk),
        .arst_n       (arst_n),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .run          (run),
        .prog_len     (prog_len),
        .fetch_credit (fetch_credit),
        .instr_valid  (instr_valid),
        .instr_data   (instr_data)
    );

    instr_queue i_instr_queue (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr_data   (instr_data),
        .fetch_credit (fetch_credit),
        .exec_credit  (exec_credit),
        .exec_valid   (exec_valid),
        .exec_instr   (exec_instr)
    );

    exec_unit i_exec_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .exec_valid  (exec_valid),
        .exec_instr  (exec_instr),
        .exec_credit (exec_credit),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .rx_ready    (rx_ready),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .tx_ready    (tx_ready)
    );

endmodule

`default_nettype wire

//--- sim/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;
    import cpu_pkg::*;

    localparam int CLK_HALF  = 10;
    localparam int TIMEOUT   = 3000;
    localparam int MAX_PROG  = 128;
    localparam int MAX_BYTES = 512;

    logic   clk = 1'b0;
    logic   arst_n;
    logic   prog_we;
    pc_t    prog_addr;
    instr_t prog_data;
    logic   run;
    pc_t    prog_len;
    logic   rx_valid;
    byte_t  rx_data;
    logic   rx_ready;
    logic   tx_valid;
    byte_t  tx_data;
    logic   tx_ready;

    integer seed = 74;
    string  test_name = "none";
    int     mismatch_cnt = 0;
    int     extra_cnt = 0;
    int     timeout_cnt = 0;
    int     other_cnt = 0;

    // program under construction
    instr_t  pg_word [MAX_PROG];
    opcode_e pg_op [MAX_PROG];
    dev_t    pg_dev [MAX_PROG];
    byte_t   pg_lo [MAX_PROG];
    int      pg_len = 0;

    // reference machine state
    byte_t m_a;
    byte_t m_x;
    byte_t m_y;
    byte_t m_m;
    byte_t m_ram [RAM_BYTES];
    int    m_rx = 0;

    // expected transmit stream and receive stimulus
    byte_t exp_mem [MAX_BYTES];
    int    exp_wr = 0;
    int    exp_rd = 0;
    byte_t rx_mem [MAX_BYTES];
    int    rx_wr = 0;
    int    rx_rd = 0;
    logic  tx_fire = 1'b0;
    logic  rx_fire = 1'b0;
    logic  tx_stall = 1'b0;

    cpu_core i_cpu_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .run       (run),
        .prog_len  (prog_len),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready)
    );

    always #CLK_HALF clk = ~clk;

    // handshakes seen mid cycle complete at the next edge
    always @(negedge clk) begin
        tx_fire = tx_valid && tx_ready;
        rx_fire = rx_valid && rx_ready;
    end

    // uart side stimulus, 2 ns after the edge
    always @(posedge clk) begin
        #2;
        if (tx_fire) begin
            exp_rd = exp_rd + 1;
        end
        if (rx_fire) begin
            rx_rd    = rx_rd + 1;
            rx_valid = 1'b0;
        end
        if (tx_stall) begin
            tx_ready = (($random(seed) & 3) != 0);
        end else begin
            tx_ready = 1'b1;
        end
        // held once raised, random gap before the next byte
        if (!rx_valid && rx_rd < rx_wr && (($random(seed) & 3) == 0)) begin
            rx_valid = 1'b1;
            rx_data  = rx_mem[rx_rd];
        end
    end

    // accepted byte against the model, in order
    assert property (@(posedge clk) disable iff (!arst_n)
        (tx_valid && tx_ready && exp_rd < exp_wr) |-> tx_data == exp_mem[exp_rd])
    else begin
        mismatch_cnt++;
        $display("Mismatch %s: expected %h actual %h",
                 test_name, exp_mem[exp_rd], $sampled(tx_data));
    end

    // nothing beyond the expected stream
    assert property (@(posedge clk) disable iff (!arst_n)
        (tx_valid && tx_ready) |-> exp_rd < exp_wr)
    else begin
        extra_cnt++;
        $display("Error in %s: byte %h sent when none was expected",
                 test_name, $sampled(tx_data));
    end

    // quiet uart while stopped
    assert property (@(posedge clk) disable iff (!arst_n)
        !run |-> !tx_valid && !rx_ready)
    else begin
        other_cnt++;
        $display("Error in %s: tx_valid or rx_ready high while not running", test_name);
    end

    function automatic byte_t alu_model(input logic [2:0] code, input byte_t x,
                                        input byte_t y);
        byte_t r;
        case (code)
            alu_add:    r = x + y;
            alu_sub:    r = x - y;
            alu_and:    r = x & y;
            alu_or:     r = x | y;
            alu_xor:    r = x ^ y;
            alu_pass_x: r = x;
            alu_pass_y: r = y;
            default:    r = 8'h00;
        endcase
        return r;
    endfunction

    // op in 7:5, device bit 4 sits in bit 0 above the low byte
    function automatic instr_t encode(input opcode_e op, input dev_t dev, input byte_t lo);
        return {op, dev[3:0], dev[4], lo};
    endfunction

    // one instruction on the reference machine
    task automatic model_step(input opcode_e op, input dev_t dev, input byte_t lo);
        byte_t val;
        byte_t x_opnd;
        case (op)
            op_dev_rom:   val = lo;
            op_dev_ram:   val = m_ram[m_m];
            op_dev_ramzp: val = m_ram[lo];
            op_dev_uart, op_ramzp_uart: begin
                val = rx_mem[m_rx];
                m_rx++;
            end
            op_nonreg_opregy: val = alu_model(lo[2:0], 8'h00, m_y);
            op_regx_alu: begin
                // bit 3 of the low byte takes A as the X operand
                x_opnd = lo[3] ? m_a : m_x;
                val    = alu_model(lo[2:0], x_opnd, m_y);
            end
            op_ramzp_reg: val = m_x;
            default:      val = 8'h00;
        endcase
        if (op == op_ramzp_reg || op == op_ramzp_uart) begin
            m_ram[lo] = val;
        end else begin
            case (dev)
                dev_reg_a: m_a = val;
                dev_reg_x: m_x = val;
                dev_reg_y: m_y = val;
                dev_reg_m: m_m = val;
                dev_ram:   m_ram[m_m] = val;
                dev_uart_tx: begin
                    exp_mem[exp_wr] = val;
                    exp_wr++;
                end
                default: ;
            endcase
        end
    endtask

    task automatic begin_program(input string name);
        @(negedge clk);
        test_name = name;
        pg_len    = 0;
    endtask

    task automatic add_instr(input opcode_e op, input dev_t dev, input byte_t lo);
        pg_op[pg_len]   = op;
        pg_dev[pg_len]  = dev;
        pg_lo[pg_len]   = lo;
        pg_word[pg_len] = encode(op, dev, lo);
        pg_len++;
    endtask

    task automatic add_rx(input byte_t b);
        rx_mem[rx_wr] = b;
        rx_wr++;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;
    endtask

    task automatic wait_tx_done(output bit ok);
        int cycles;
        cycles = 0;
        while (exp_rd != exp_wr && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = (exp_rd == exp_wr);
        if (!ok) begin
            timeout_cnt++;
            $display("Timeout in %s: only %0d of %0d expected bytes were sent",
                     test_name, exp_rd, exp_wr);
        end
    endtask

    // reset, load, model, run until the last byte leaves
    task automatic run_program();
        bit ok;
        int k;
        if (timeout_cnt != 0) begin
            return;
        end
        apply_reset();
        for (k = 0; k < pg_len; k++) begin
            prog_we   = 1'b1;
            prog_addr = pc_t'(k);
            prog_data = pg_word[k];
            @(posedge clk);
            #2;
        end
        prog_we = 1'b0;
        // registers come out of reset at zero, ram keeps its contents
        m_a = 8'h00;
        m_x = 8'h00;
        m_y = 8'h00;
        m_m = 8'h00;
        for (k = 0; k < pg_len; k++) begin
            model_step(pg_op[k], pg_dev[k], pg_lo[k]);
        end
        prog_len = pc_t'(pg_len);
        run      = 1'b1;
        wait_tx_done(ok);
        if (ok) begin
            // window for stray bytes
            repeat (10) @(negedge clk);
            assert (rx_rd == rx_wr)
            else begin
                other_cnt++;
                $display("Error in %s: %0d received bytes were never taken",
                         test_name, rx_wr - rx_rd);
            end
        end
        @(posedge clk);
        #2;
        run = 1'b0;
    endtask

    task automatic test_imm_uart();
        begin_program("imm_uart");
        add_instr(op_dev_rom, dev_uart_tx, 8'h5a);
        add_instr(op_dev_rom, dev_uart_tx, 8'ha5);
        add_instr(op_dev_rom, dev_uart_tx, 8'h00);
        add_instr(op_dev_rom, dev_uart_tx, 8'hff);
        run_program();
    endtask

    task automatic test_alu();
        int p;
        int c;
        byte_t xs [2];
        byte_t ys [2];
        xs = '{8'h9c, 8'h21};
        ys = '{8'h37, 8'hc8};
        begin_program("alu_regs");
        for (p = 0; p < 2; p++) begin
            add_instr(op_dev_rom, dev_reg_x, xs[p]);
            add_instr(op_dev_rom, dev_reg_y, ys[p]);
            for (c = 0; c < 7; c++) begin
                add_instr(op_regx_alu, dev_reg_a, byte_t'(c));
                // A out through Y, then Y restored
                add_instr(op_regx_alu, dev_reg_y, {5'b00001, alu_pass_x});
                add_instr(op_nonreg_opregy, dev_uart_tx, {5'b00000, alu_pass_y});
                add_instr(op_dev_rom, dev_reg_y, ys[p]);
            end
        end
        add_instr(op_dev_rom, dev_uart_tx, 8'h81);
        run_program();
    endtask

    task automatic test_ram();
        begin_program("ram_paths");
        add_instr(op_dev_rom, dev_reg_x, 8'h11);
        add_instr(op_ramzp_reg, dev_none, 8'h20);
        add_instr(op_dev_ramzp, dev_uart_tx, 8'h20);
        add_instr(op_dev_rom, dev_reg_m, 8'h40);
        add_instr(op_dev_rom, dev_ram, 8'h77);
        add_instr(op_dev_ram, dev_uart_tx, 8'h00);
        add_instr(op_dev_rom, dev_reg_x, 8'hc3);
        add_instr(op_ramzp_reg, dev_none, 8'h41);
        add_instr(op_dev_rom, dev_reg_m, 8'h41);
        add_instr(op_dev_ram, dev_uart_tx, 8'h00);
        add_instr(op_dev_ramzp, dev_uart_tx, 8'h40);
        add_instr(op_dev_rom, dev_reg_y, 8'h0f);
        add_instr(op_nonreg_opregy, dev_uart_tx, {5'b00000, alu_sub});
        add_instr(op_nonreg_opregy, dev_uart_tx, {5'b00000, alu_or});
        run_program();
    endtask

    task automatic test_rx();
        begin_program("uart_rx");
        add_rx(8'h12);
        add_rx(8'h34);
        add_rx(8'h56);
        add_rx(8'h78);
        add_rx(8'h9a);
        add_instr(op_dev_uart, dev_uart_tx, 8'h00);
        add_instr(op_ramzp_uart, dev_none, 8'h50);
        add_instr(op_dev_uart, dev_reg_x, 8'h00);
        add_instr(op_dev_uart, dev_uart_tx, 8'h00);
        add_instr(op_ramzp_uart, dev_none, 8'h51);
        add_instr(op_dev_ramzp, dev_uart_tx, 8'h50);
        add_instr(op_dev_ramzp, dev_uart_tx, 8'h51);
        add_instr(op_ramzp_reg, dev_none, 8'h52);
        add_instr(op_dev_ramzp, dev_uart_tx, 8'h52);
        run_program();
    endtask

    task automatic test_backpressure();
        int i;
        begin_program("tx_backpressure");
        tx_stall = 1'b1;
        add_instr(op_dev_rom, dev_reg_x, byte_t'($random(seed)));
        add_instr(op_dev_rom, dev_reg_y, byte_t'($random(seed)));
        for (i = 0; i < 12; i++) begin
            add_instr(op_regx_alu, dev_reg_y, {5'b00000, alu_add});
            if (i % 3 == 0) begin
                add_rx(byte_t'($random(seed)));
                add_instr(op_dev_uart, dev_uart_tx, 8'h00);
            end
            add_instr(op_dev_rom, dev_uart_tx, byte_t'($random(seed)));
            add_instr(op_nonreg_opregy, dev_uart_tx, {5'b00000, alu_pass_y});
        end
        run_program();
        tx_stall = 1'b0;
    endtask

    initial begin
        arst_n    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        run       = 1'b0;
        prog_len  = '0;
        rx_valid  = 1'b0;
        rx_data   = '0;
        tx_ready  = 1'b0;
        apply_reset();
        // stopped core, the idle assertion watches
        test_name = "idle_after_reset";
        repeat (8) @(posedge clk);
        test_imm_uart();
        test_alu();
        test_ram();
        test_rx();
        test_backpressure();
        @(negedge clk);
        $display("errors: %0d mismatches, %0d extra bytes, %0d timeouts, %0d other",
                 mismatch_cnt, extra_cnt, timeout_cnt, other_cnt);
        if (mismatch_cnt + extra_cnt + timeout_cnt + other_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/cpu_pkg.sv
hw/control_selector.sv
hw/program_fetch.sv
hw/instr_queue.sv
hw/exec_unit.sv
hw/cpu_core.sv
sim/cpu_core_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - hw/cpu_pkg.sv
  - hw/control_selector.sv
  - hw/program_fetch.sv
  - hw/instr_queue.sv
  - hw/exec_unit.sv
  - hw/cpu_core.sv
  - target: simulation
    files:
      - sim/cpu_core_tb.sv
